// ==== project.f ====
+incdir+verilog
verilog/lsu_pkg.sv
verilog/mem_issue_stage.sv
verilog/data_ram.sv
verilog/load_format.sv
verilog/lsu_exec.sv
verilog/lsu_top.sv
testbench/lsu_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log.
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module lsu_tb -f project.f -Mdir obj_dir -o Vlsu_tb

status=0
./obj_dir/Vlsu_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Done: errors found" sim.log; then
	echo "FAIL: see sim.log"
	exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "Done: no errors" sim.log; then
	echo "FAIL: simulation did not finish cleanly"
	exit 1
fi
echo "PASS"

// ==== testbench/lsu_tb.sv ====
`include "lsu_defines.svh"

module lsu_tb
	import lsu_pkg::*;
();

	localparam int FILL_CYCLES = (1 << `LSU_MEM_AW) / 4;
	localparam int MIX_CYCLES  = 500;
	localparam int KILL_CYCLES = 500;
	localparam int CYCLE_LIMIT = 16 + 8 + FILL_CYCLES + MIX_CYCLES + KILL_CYCLES + 4 + 64;
	localparam mem_uop_t IDLE_UOP = '0;

	logic       i_clk;
	logic       i_rst;
	mem_uop_t   i_uop;
	brmask_t    i_brkill;
	brmask_t    i_brresolve;
	wb_result_t o_bypass;
	wb_result_t o_wb;

	integer     seed = 14;
	string      test_name = "reset";
	int         cycles = 0;
	logic [7:0] mem_model [0:(1 << `LSU_MEM_AW)-1];
	mem_uop_t   m_held = '0; // Micro-op the issue register should hold.
	wb_result_t m_wb = '0;
	wb_result_t exp_now;
	logic       model_ready = 1'b0;

	lsu_top u_dut
	(
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_uop       (i_uop),
		.i_brkill    (i_brkill),
		.i_brresolve (i_brresolve),
		.o_bypass    (o_bypass),
		.o_wb        (o_wb)
	);

	initial
	begin
		i_clk = 1'b0;
		forever
		begin
			#20 i_clk = ~i_clk;
		end
	end

	function automatic word_t rand32();
		rand32 = $random(seed);
	endfunction

	function automatic int access_size(input funct3_t f3);
		if (f3 == F3_W)
		begin
			return 4;
		end
		if (f3 == F3_H || f3 == F3_HU)
		begin
			return 2;
		end
		return 1;
	endfunction

	// Byte k of the access, with the address bits below the size dropped.
	function automatic mem_addr_t byte_addr(input mem_uop_t u, input int k);
		word_t     sum;
		mem_addr_t a;
		sum = u.op1 + {{20{u.imm[11]}}, u.imm};
		a   = sum[`LSU_MEM_AW-1:0] & ~mem_addr_t'(access_size(u.funct3) - 1);
		return a + mem_addr_t'(k);
	endfunction

	function automatic word_t model_load(input mem_uop_t u);
		word_t w;
		w = '0;
		for (int k = 0; k < access_size(u.funct3); k++)
		begin
			w[k*8 +: 8] = mem_model[byte_addr(u, k)]; // Little endian.
		end
		if (u.funct3 == F3_B)
		begin
			w = {{24{w[7]}}, w[7:0]};
		end
		else if (u.funct3 == F3_H)
		begin
			w = {{16{w[15]}}, w[15:0]};
		end
		return w;
	endfunction

	function automatic logic live(input mem_uop_t u);
		return u.valid && !(|(u.brmask & i_brkill));
	endfunction

	function automatic wb_result_t expected_bypass();
		wb_result_t r;
		r = '0;
		if (live(m_held) && m_held.opcode == OPC_LOAD)
		begin
			r.valid = 1'b1;
			r.rd    = m_held.rd;
			r.data  = model_load(m_held);
		end
		return r;
	endfunction

	// Advances the model by one clock edge using the inputs of the ending cycle.
	task automatic model_step();
		if (live(m_held) && m_held.opcode == OPC_STORE)
		begin
			for (int k = 0; k < access_size(m_held.funct3); k++)
			begin
				mem_model[byte_addr(m_held, k)] = m_held.op2[k*8 +: 8];
			end
		end
		if (i_rst)
		begin
			m_wb = '0;
		end
		else
		begin
			m_wb = expected_bypass();
		end
		m_held        = i_uop;
		m_held.valid  = !i_rst && i_uop.valid && !(|(i_uop.brmask & i_brkill));
		m_held.brmask = i_uop.brmask & ~i_brresolve;
		model_ready   = 1'b1;
	endtask

	task automatic step(input mem_uop_t u, input brmask_t kill, input brmask_t res,
		input logic rst);
		@(posedge i_clk);
		model_step();
		i_uop       <= u;
		i_brkill    <= kill;
		i_brresolve <= res;
		i_rst       <= rst;
	endtask

	task automatic check_value(input string what, input word_t expected, input word_t actual);
		if (expected !== actual)
		begin
			$display("error: %s %s expected %h actual %h", test_name, what, expected, actual);
			$display("Done: errors found");
			$fatal(1);
		end
	endtask

	task automatic check_result(input string what, input wb_result_t expected,
		input wb_result_t actual);
		check_value({what, " valid"}, word_t'(expected.valid), word_t'(actual.valid));
		if (expected.valid)
		begin
			check_value({what, " rd"}, word_t'(expected.rd), word_t'(actual.rd));
			check_value({what, " data"}, expected.data, actual.data);
		end
	endtask

	function automatic mem_uop_t random_uop();
		mem_uop_t   u;
		word_t      r;
		word_t      base;
		mem_addr_t  addr;
		logic [2:0] kind;
		r        = rand32();
		kind     = r[2:0];
		u.valid  = (kind != 3'd7);
		u.rd     = r[`LSU_REG_W+2:3];
		u.brmask = r[`LSU_BRM_W+15:16] & r[`LSU_BRM_W+23:24]; // Sparse masks.
		r        = rand32();
		u.imm    = r[11:0];
		addr     = r[`LSU_MEM_AW+11:12];
		u.op2    = rand32();
		r        = rand32();
		if (kind <= 3'd2)
		begin
			u.opcode = OPC_LOAD;
			case (r[2:0])
				3'd0:    u.funct3 = F3_B;
				3'd1:    u.funct3 = F3_H;
				3'd2:    u.funct3 = F3_W;
				3'd3:    u.funct3 = F3_BU;
				default: u.funct3 = F3_HU;
			endcase
		end
		else if (kind <= 3'd5)
		begin
			u.opcode = OPC_STORE;
			case (r[1:0])
				2'd0:    u.funct3 = F3_B;
				2'd1:    u.funct3 = F3_H;
				default: u.funct3 = F3_W;
			endcase
		end
		else
		begin
			u.opcode = r[9:3];
			u.funct3 = r[12:10];
			if (u.opcode == OPC_LOAD || u.opcode == OPC_STORE)
			begin
				u.opcode = 7'b0110011; // An ALU opcode instead.
			end
		end
		base  = rand32();
		u.op1 = {base[31:`LSU_MEM_AW], addr} - {{20{u.imm[11]}}, u.imm};
		return u;
	endfunction

	// Outputs are settled in the middle of the cycle.
	// The expected writeback is the expected bypass of the cycle before.
	always @(negedge i_clk)
	begin
		if (model_ready)
		begin
			exp_now = expected_bypass();
			check_result("bypass", exp_now, o_bypass);
			check_result("writeback", m_wb, o_wb);
		end
	end

	always @(posedge i_clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout: the run went past %0d cycles", CYCLE_LIMIT);
			$display("Done: errors found");
			$fatal(1);
		end
	end

	initial
	begin
		mem_uop_t u;
		word_t    r;
		brmask_t  kill;
		brmask_t  res;
		i_rst       = 1'b1;
		i_uop       = IDLE_UOP;
		i_brkill    = '0;
		i_brresolve = '0;
		repeat (15)
		begin
			step(IDLE_UOP, '0, '0, 1'b1);
		end
		test_name = "idle";
		repeat (9)
		begin
			step(IDLE_UOP, '0, '0, 1'b0);
		end
		test_name = "fill";
		for (int i = 0; i < FILL_CYCLES; i++)
		begin
			u        = IDLE_UOP;
			u.valid  = 1'b1;
			u.opcode = OPC_STORE;
			u.funct3 = F3_W;
			u.op1    = i * 4;
			u.op2    = (u.op1 * 32'h9e3779b1) ^ 32'h13579bdf;
			step(u, '0, '0, 1'b0);
		end
		test_name = "store_load";
		repeat (MIX_CYCLES)
		begin
			step(random_uop(), '0, '0, 1'b0);
		end
		test_name = "kill_resolve";
		repeat (KILL_CYCLES)
		begin
			r    = rand32();
			kill = (r[1:0] == 2'b00) ? (brmask_t'(1) << r[3:2]) : '0;
			res  = (r[5:4] == 2'b00) ? r[`LSU_BRM_W+7:8] : '0;
			step(random_uop(), kill, res, 1'b0);
		end
		test_name = "drain";
		repeat (4)
		begin
			step(IDLE_UOP, '0, '0, 1'b0);
		end
		@(posedge i_clk);
		$display("Done: no errors");
		$finish;
	end

endmodule

// ==== verilog/lsu_top.sv ====
module lsu_top
	import lsu_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_rst,
	input  mem_uop_t   i_uop,
	input  brmask_t    i_brkill,
	input  brmask_t    i_brresolve,
	output wb_result_t o_bypass,
	output wb_result_t o_wb
);

	mem_uop_t s_issue; // Kill-qualified micro-op from the issue register.

	mem_issue_stage u_issue
	(
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_uop       (i_uop),
		.i_brkill    (i_brkill),
		.i_brresolve (i_brresolve),
		.o_uop       (s_issue)
	);

	lsu_exec u_exec
	(
		.i_clk    (i_clk),
		.i_rst    (i_rst),
		.i_uop    (s_issue),
		.o_bypass (o_bypass),
		.o_wb     (o_wb)
	);

endmodule

// ==== verilog/lsu_exec.sv ====
`include "lsu_defines.svh"

module lsu_exec
	import lsu_pkg::*;
(
	input  logic       i_clk,
	input  logic       i_rst,
	input  mem_uop_t   i_uop,
	output wb_result_t o_bypass,
	output wb_result_t o_wb
);

	word_t      eff_addr;
	mem_addr_t  mem_addr;
	mem_addr_t  ram_addr;
	logic [1:0] offset;
	logic       is_load;
	logic       is_store;
	byte_en_t   store_be;
	word_t      store_data;
	byte_en_t   ram_we;
	word_t      ram_rdata;
	word_t      load_data;
	logic       wb_valid;
	reg_idx_t   wb_rd;
	word_t      wb_data;

	assign eff_addr = i_uop.op1 + {{20{i_uop.imm[11]}}, i_uop.imm};
	assign mem_addr = eff_addr[`LSU_MEM_AW-1:0];
	assign offset   = mem_addr[1:0];
	assign ram_addr = {mem_addr[`LSU_MEM_AW-1:2], 2'b00};

	assign is_load  = i_uop.valid && (i_uop.opcode == OPC_LOAD);
	assign is_store = i_uop.valid && (i_uop.opcode == OPC_STORE);

	// Store data is replicated across lanes so the enables alone pick the position.
	always_comb
	begin
		case (i_uop.funct3)
			F3_B:
			begin
				store_be   = 4'b0001 << offset;
				store_data = {4{i_uop.op2[7:0]}};
			end
			F3_H:
			begin
				store_be   = offset[1] ? 4'b1100 : 4'b0011;
				store_data = {2{i_uop.op2[15:0]}};
			end
			default:
			begin
				store_be   = 4'b1111;
				store_data = i_uop.op2;
			end
		endcase
	end

	assign ram_we = is_store ? store_be : 4'b0000;

	data_ram u_ram
	(
		.i_clk   (i_clk),
		.i_addr  (ram_addr),
		.i_we    (ram_we),
		.i_wdata (store_data),
		.o_rdata (ram_rdata)
	);

	load_format u_fmt
	(
		.i_word   (ram_rdata),
		.i_offset (offset),
		.i_funct3 (i_uop.funct3),
		.o_data   (load_data)
	);

	always_comb
	begin
		o_bypass.valid = is_load;
		o_bypass.rd    = i_uop.rd;
		o_bypass.data  = load_data;
	end

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			wb_valid <= 1'b0;
		end
		else
		begin
			wb_valid <= o_bypass.valid;
		end
	end

	always_ff @(posedge i_clk)
	begin
		wb_rd   <= o_bypass.rd;
		wb_data <= o_bypass.data;
	end

	assign o_wb = '{valid: wb_valid, rd: wb_rd, data: wb_data};

endmodule

// ==== verilog/load_format.sv ====
module load_format
	import lsu_pkg::*;
(
	input  word_t      i_word,
	input  logic [1:0] i_offset,
	input  funct3_t    i_funct3,
	output word_t      o_data
);

	logic [7:0]  sel_byte;
	logic [15:0] sel_half;

	always_comb
	begin
		case (i_offset)
			2'd0:    sel_byte = i_word[7:0];
			2'd1:    sel_byte = i_word[15:8];
			2'd2:    sel_byte = i_word[23:16];
			default: sel_byte = i_word[31:24];
		endcase

		// Misaligned halfwords are not supported.
		sel_half = i_offset[1] ? i_word[31:16] : i_word[15:0];
	end

	always_comb
	begin
		case (i_funct3)
			F3_B:
			begin
				o_data = {{24{sel_byte[7]}}, sel_byte};
			end
			F3_H:
			begin
				o_data = {{16{sel_half[15]}}, sel_half};
			end
			F3_BU:
			begin
				o_data = {24'b0, sel_byte};
			end
			F3_HU:
			begin
				o_data = {16'b0, sel_half};
			end
			default:
			begin
				o_data = i_word; // LW and the reserved codes take the whole word.
			end
		endcase
	end

endmodule

// ==== verilog/data_ram.sv ====
`include "lsu_defines.svh"

module data_ram
	import lsu_pkg::*;
(
	input  logic      i_clk,
	input  mem_addr_t i_addr,
	input  byte_en_t  i_we,
	input  word_t     i_wdata,
	output word_t     o_rdata
);

	localparam int WORDS = (1 << `LSU_MEM_AW) / 4;
	localparam int IDX_W = `LSU_MEM_AW - 2;

	logic [3:0][7:0]  mem [0:WORDS-1]; // Four byte lanes per word.
	logic [IDX_W-1:0] word_idx;

	// The address is word aligned so only the upper bits select a row.
	assign word_idx = i_addr[`LSU_MEM_AW-1:2];

	assign o_rdata = mem[word_idx];

	always_ff @(posedge i_clk)
	begin
		for (int lane = 0; lane < 4; lane++)
		begin
			if (i_we[lane])
			begin
				mem[word_idx][lane] <= i_wdata[lane*8 +: 8];
			end
		end
	end

endmodule

// ==== verilog/mem_issue_stage.sv ====
module mem_issue_stage
	import lsu_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_rst,
	input  mem_uop_t i_uop,
	input  brmask_t  i_brkill,
	input  brmask_t  i_brresolve,
	output mem_uop_t o_uop
);

	logic     held_valid;
	mem_uop_t held_uop;
	logic     in_killed;
	logic     held_killed;

	function automatic logic br_overlap(input brmask_t mask, input brmask_t kill);
		br_overlap = |(mask & kill);
	endfunction

	// A kill hits both the micro-op being captured and the one held here.
	always_comb
	begin
		in_killed   = br_overlap(i_uop.brmask, i_brkill);
		held_killed = br_overlap(held_uop.brmask, i_brkill);
	end

	always_ff @(posedge i_clk)
	begin
		if (i_rst)
		begin
			held_valid <= 1'b0;
		end
		else
		begin
			held_valid <= i_uop.valid && !in_killed;
		end
	end

	// Resolved branches drop out of the mask so a reused tag cannot squash this entry.
	always_ff @(posedge i_clk)
	begin
		held_uop        <= i_uop;
		held_uop.brmask <= i_uop.brmask & ~i_brresolve;
	end

	always_comb
	begin
		o_uop        = held_uop;
		o_uop.valid  = held_valid && !held_killed;
		o_uop.brmask = held_uop.brmask & ~i_brresolve;
	end

endmodule

// ==== verilog/lsu_pkg.sv ====
`include "lsu_defines.svh"

package lsu_pkg;

	typedef logic [31:0]             word_t;
	typedef logic [`LSU_REG_W-1:0]   reg_idx_t;
	typedef logic [`LSU_BRM_W-1:0]   brmask_t;
	typedef logic [`LSU_MEM_AW-1:0]  mem_addr_t;
	typedef logic [6:0]              opcode_t;
	typedef logic [2:0]              funct3_t;
	typedef logic [11:0]             imm_t;
	typedef logic [3:0]              byte_en_t; // One enable per byte lane.

	localparam opcode_t OPC_LOAD  = 7'b0000011;
	localparam opcode_t OPC_STORE = 7'b0100011;

	// Access size codes, shared by loads and stores.
	localparam funct3_t F3_B  = 3'b000;
	localparam funct3_t F3_H  = 3'b001;
	localparam funct3_t F3_W  = 3'b010;
	localparam funct3_t F3_BU = 3'b100;
	localparam funct3_t F3_HU = 3'b101;

	typedef struct packed
	{
		logic     valid;
		opcode_t  opcode;
		brmask_t  brmask; // Branches this micro-op depends on.
		reg_idx_t rd;
		funct3_t  funct3;
		imm_t     imm;
		word_t    op1;    // Base address.
		word_t    op2;    // Store data.
	} mem_uop_t;

	typedef struct packed
	{
		logic     valid;
		reg_idx_t rd;
		word_t    data;
	} wb_result_t;

endpackage

// ==== verilog/lsu_defines.svh ====
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Byte address width of the data RAM.
`define LSU_MEM_AW 10 // 1 KiB of byte-addressed memory.

// Architectural register index width.
`define LSU_REG_W 5

// One mask bit per in-flight branch tag.
`define LSU_BRM_W 4

`endif
